// File: run_sim.sh
#!/bin/sh
# build and run the UPDI programmer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_updi_prog -o sim_updi_prog
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_updi_prog > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -qx "TEST PASS" sim.log || exit 1
exit 0

// File: tb_updi_prog.sv
// UPDI programmer testbench
`timescale 1ns/1ps

module tb_updi_prog import updi_proto_pkg::*, updi_prog_pkg::*; ();

	// pattern file layout
	localparam int KEY_FRAME_LEN = 10;
	localparam int TEST_BASE     = 11;
	localparam int TEST_FIELDS   = 9;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic busy;
	logic done;
	prog_err_e err_code;
	logic [23:0] device_id;
	logic [7:0] tx_byte;
	logic tx_valid;
	logic tx_ready;
	logic [7:0] rx_byte;
	logic rx_valid;
	logic rx_ready;
	logic break_start;
	logic break_done;

	logic [7:0] pat [0:255];
	logic [7:0] rx_q [$];
	logic [7:0] fr_buf [$];
	logic [7:0] key_seen [$];
	logic rx_fire;
	logic [2:0] fr_class;
	int fr_state;
	int fr_left;
	int brk_cnt;

	// target behavior for the current test
	logic [7:0] p_statusa;
	logic [7:0] p_keystat;
	logic [7:0] p_ack;
	logic [7:0] p_id [0:2];
	logic p_silent;
	int p_nbusy;

	int sys_reads;
	int polls_at_sig;
	int key_frames;
	int proto_errs;
	int errors;
	int passed;
	int n_tests;
	int max_polls;
	int wd_cycles;

	updi_prog_top i_updi_prog_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic reply_status(input logic [3:0] addr);
		case (addr)
			CS_STATUSA: rx_q.push_back(p_statusa);
			CS_KEY_STATUS: rx_q.push_back(p_keystat);
			CS_SYS_STATUS: begin
				// erase still running while bit 0 is set
				rx_q.push_back((sys_reads < p_nbusy) ? 8'h01 : 8'h00);
				sys_reads++;
			end
			default: rx_q.push_back(8'h00);
		endcase
	endtask

	// target side frame parser fed one byte at a time
	task automatic handle_tx_byte(input logic [7:0] b);
		if (fr_state == 0) begin
			fr_buf.delete();
		end
		fr_buf.push_back(b);
		if (fr_state == 0) begin
			if (b == UPDI_SYNC) begin
				fr_state = 1;
			end else begin
				$display("target saw byte %h outside a frame", b);
				proto_errs++;
			end
		end else if (fr_state == 1) begin
			fr_class = b[7:5];
			fr_state = 0;
			case (b[7:5])
				OP_LDCS: reply_status(b[3:0]);
				OP_LD: begin
					if (!p_silent) begin
						rx_q.push_back(p_id[0]);
						rx_q.push_back(p_id[1]);
						rx_q.push_back(p_id[2]);
					end
				end
				OP_KEY: begin
					fr_left = 8;
					fr_state = 2;
				end
				OP_STCS, OP_REPEAT: begin
					fr_left = 1;
					fr_state = 2;
				end
				OP_ST: begin
					if (polls_at_sig < 0) begin
						polls_at_sig = sys_reads;
					end
					fr_left = 2;
					fr_state = 2;
				end
				default: begin
					$display("target saw unexpected opcode %h", b);
					proto_errs++;
				end
			endcase
		end else begin
			fr_left--;
			if (fr_left == 0) begin
				fr_state = 0;
				if (fr_class == OP_KEY) begin
					key_seen = fr_buf;
					key_frames++;
				end
				// ack after the pointer address
				if (fr_class == OP_ST) begin
					rx_q.push_back(p_ack);
				end
			end
		end
	endtask

	// target device responder working on the falling edge
	initial begin
		tx_ready = 1'b0;
		rx_valid = 1'b0;
		rx_byte = 8'h00;
		break_done = 1'b0;
		rx_fire = 1'b0;
		brk_cnt = 0;
		fr_state = 0;
		fr_left = 0;
		proto_errs = 0;
		forever begin
			@(negedge clk);
			// byte taken by the DUT on the edge just past
			if (rx_fire) begin
				rx_q.delete(0);
			end
			if (rx_q.size() != 0) begin
				rx_valid = 1'b1;
				rx_byte = rx_q[0];
			end else begin
				rx_valid = 1'b0;
			end
			break_done = 1'b0;
			if (break_start) begin
				brk_cnt = 6;
			end else if (brk_cnt != 0) begin
				brk_cnt--;
				if (brk_cnt == 0) begin
					break_done = 1'b1;
				end
			end
			tx_ready = ($urandom % 4) != 0;
			if (tx_valid && tx_ready) begin
				handle_tx_byte(tx_byte);
			end
			rx_fire = rx_valid && rx_ready;
		end
	end

	task automatic run_test(input int idx);
		int base;
		int errs_before;
		int proto_before;
		bit test_ok;
		prog_err_e exp_err;
		logic [23:0] exp_id;
		base = TEST_BASE + idx * TEST_FIELDS;
		errs_before = errors;
		proto_before = proto_errs;
		p_statusa = pat[base];
		p_keystat = pat[base + 1];
		p_nbusy = int'(pat[base + 2]);
		p_ack = pat[base + 3];
		p_silent = pat[base + 4][0];
		p_id[0] = pat[base + 5];
		p_id[1] = pat[base + 6];
		p_id[2] = pat[base + 7];
		exp_err = prog_err_e'(pat[base + 8][2:0]);
		exp_id = {pat[base + 5], pat[base + 6], pat[base + 7]};
		sys_reads = 0;
		polls_at_sig = -1;
		key_frames = 0;

		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		assert (busy) else begin
			$display("busy did not rise after start");
			errors++;
		end
		while (done !== 1'b1) @(negedge clk);

		assert (err_code == exp_err) else begin
			$display("MISMATCH err_code: got %h expected %h", err_code, exp_err);
			errors++;
		end
		assert (!busy) else begin
			$display("busy still high when done pulsed");
			errors++;
		end
		if (exp_err == ERR_NONE) begin
			assert (device_id == exp_id) else begin
				$display("MISMATCH device_id: got %h expected %h", device_id, exp_id);
				errors++;
			end
		end
		// sessions stopped by a status check never poll
		if (exp_err == ERR_STATUS_ZERO || exp_err == ERR_KEY_REJECTED) begin
			assert (sys_reads == 0) else begin
				$display("MISMATCH sys_status_reads: got %h expected %h", sys_reads, 0);
				errors++;
			end
		end else begin
			assert (polls_at_sig == p_nbusy + 1) else begin
				$display("MISMATCH sys_status_reads: got %h expected %h",
					polls_at_sig, p_nbusy + 1);
				errors++;
			end
		end
		if (exp_err != ERR_STATUS_ZERO) begin
			assert (key_frames == 1) else begin
				$display("MISMATCH key_frames: got %h expected %h", key_frames, 1);
				errors++;
			end
			assert (key_seen.size() == KEY_FRAME_LEN) else begin
				$display("MISMATCH key_frame_len: got %h expected %h",
					key_seen.size(), KEY_FRAME_LEN);
				errors++;
			end
			if (key_seen.size() == KEY_FRAME_LEN) begin
				for (int i = 0; i < KEY_FRAME_LEN; i++) begin
					assert (key_seen[i] == pat[i]) else begin
						$display("MISMATCH key_frame[%0d]: got %h expected %h",
							i, key_seen[i], pat[i]);
						errors++;
					end
				end
			end
		end else begin
			assert (key_frames == 0) else begin
				$display("MISMATCH key_frames: got %h expected %h", key_frames, 0);
				errors++;
			end
		end

		// let a frame cut short by an error run out
		repeat (20) @(negedge clk);
		test_ok = (errors == errs_before) && (proto_errs == proto_before);
		if (test_ok) begin
			passed++;
		end
		$display("test %0d %s, err_code %h", idx + 1,
			test_ok ? "passed" : "failed", err_code);
	endtask

	initial begin
		wait (wd_cycles != 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, a session never finished", wd_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		errors = 0;
		passed = 0;
		void'($urandom(32'hca23_936b));
		$readmemh("updi_patterns.txt", pat);
		n_tests = int'(pat[KEY_FRAME_LEN]);
		max_polls = 0;
		for (int i = 0; i < n_tests; i++) begin
			if (int'(pat[TEST_BASE + i * TEST_FIELDS + 2]) > max_polls) begin
				max_polls = int'(pat[TEST_BASE + i * TEST_FIELDS + 2]);
			end
		end
		// room for the break and all frames plus two receive timeouts and a delay per poll
		wd_cycles = 100 + n_tests * (2000 + 2 * RX_TIMEOUT_CLKS
			+ (max_polls + 2) * (RESET_DELAY_CLKS + 200));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d target errors",
			n_tests, passed, n_tests - passed, errors, proto_errs);
		if (errors == 0 && proto_errs == 0 && n_tests > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: updi_frame_tx.sv
// UPDI frame transmitter
`timescale 1ns/1ps

module updi_frame_tx import updi_proto_pkg::*, updi_prog_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  updi_cmd_t  cmd,
	input  logic       cmd_valid,
	output logic       cmd_ready,
	output logic       frame_done,
	output logic [7:0] tx_byte,
	output logic       tx_valid,
	input  logic       tx_ready,
	output logic       ack_req,
	input  logic       ack_ok
);

	updi_cmd_t cmd_q;
	logic active;
	logic ack_wait;
	// byte position: 0 is SYNC, 1 the opcode, data after that
	logic [DATA_CNT_W-1:0] idx;
	logic [ACK_IDX_W-1:0] data_sel;
	logic accept;
	logic at_ack;
	logic is_last;
	logic past_end;

	assign data_sel = ACK_IDX_W'(idx - DATA_CNT_W'(2));
	assign at_ack = cmd_q.ack_en && (idx >= DATA_CNT_W'(2)) && (data_sel == cmd_q.ack_idx);
	assign is_last = (idx == cmd_q.data_count + DATA_CNT_W'(1));
	assign past_end = (idx == cmd_q.data_count + DATA_CNT_W'(2));

	assign cmd_ready = !active;
	assign tx_valid = active && !ack_wait;
	assign accept = tx_valid && tx_ready;

	always_comb begin
		if (idx == DATA_CNT_W'(0)) begin
			tx_byte = UPDI_SYNC;
		end else if (idx == DATA_CNT_W'(1)) begin
			tx_byte = cmd_q.op;
		end else begin
			tx_byte = cmd_q.data[data_sel];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			ack_wait <= 1'b0;
			ack_req <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			ack_req <= 1'b0;
			frame_done <= 1'b0;
			if (cmd_valid && cmd_ready) begin
				cmd_q <= cmd;
				idx <= '0;
				active <= 1'b1;
			end else if (accept) begin
				idx <= idx + DATA_CNT_W'(1);
				// stall here until the target acknowledges
				if (at_ack) begin
					ack_wait <= 1'b1;
					ack_req <= 1'b1;
				end else if (is_last) begin
					active <= 1'b0;
					frame_done <= 1'b1;
				end
			end else if (ack_wait && ack_ok) begin
				ack_wait <= 1'b0;
				if (past_end) begin
					active <= 1'b0;
					frame_done <= 1'b1;
				end
			end
		end
	end

endmodule

// File: updi_patterns.txt
// key frame bytes (sync, opcode, chip-erase key lsb first), then the number of tests
// each test line has statusa, key status, busy polls, ack, silent, id0 id1 id2, err code
55 e0 65 73 61 72 45 4d 56 4e
09
30 08 00 40 00 1e 95 0f 00
30 08 03 40 00 1e 94 42 00
82 0c 01 40 00 1e 96 51 00
00 08 00 40 00 1e 95 0f 01
30 04 00 40 00 1e 95 0f 02
30 f7 00 40 00 1e 95 0f 02
30 08 01 41 00 1e 95 0f 03
30 08 02 40 01 1e 95 0f 04
ff 18 05 40 00 1e 93 28 00

// File: updi_prog_pkg.sv
// UPDI programmer types and limits
package updi_prog_pkg;

	localparam int MAX_CMD_DATA     = 8;
	localparam int MAX_RESP         = 3;
	localparam int RESET_DELAY_CLKS = 64;
	localparam int RX_TIMEOUT_CLKS  = 200;

	localparam int DATA_CNT_W = $clog2(MAX_CMD_DATA + 1);
	localparam int ACK_IDX_W  = $clog2(MAX_CMD_DATA);
	localparam int RESP_CNT_W = $clog2(MAX_RESP + 1);
	localparam int DELAY_W    = $clog2(RESET_DELAY_CLKS);
	localparam int TMO_W      = $clog2(RX_TIMEOUT_CLKS);

	// one command frame, data[0] goes out first
	typedef struct packed {
		updi_proto_pkg::updi_op_u     op;
		logic [MAX_CMD_DATA-1:0][7:0] data;
		logic [DATA_CNT_W-1:0]        data_count;
		logic [ACK_IDX_W-1:0]         ack_idx;
		logic                         ack_en;
		logic [RESP_CNT_W-1:0]        resp_count;
	} updi_cmd_t;

	// data[0] is the first byte received
	typedef struct packed {
		logic [MAX_RESP-1:0][7:0] data;
		logic [RESP_CNT_W-1:0]    count;
	} updi_resp_t;

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_STATUS_ZERO,
		ERR_KEY_REJECTED,
		ERR_BAD_ACK,
		ERR_TIMEOUT
	} prog_err_e;

endpackage

// File: updi_prog_props.sv
// UPDI handshake properties
`timescale 1ns/1ps

module updi_prog_props (
	input logic       clk,
	input logic       rst,
	input logic       start,
	input logic       busy,
	input logic       done,
	input logic [7:0] tx_byte,
	input logic       tx_valid,
	input logic       tx_ready
);

	// a stalled byte stays on the bus unchanged
	tx_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
		else $error("tx byte dropped or changed while stalled");

	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done held high for more than one cycle");

	busy_after_reset: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high right after reset");

	// only start moves an idle sequencer
	busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		!busy && !start |=> !busy)
		else $error("busy rose without start");

endmodule

bind updi_prog_top updi_prog_props i_updi_prog_props (
	.clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
	.tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready)
);

// File: updi_prog_top.sv
// UPDI programmer top level
`timescale 1ns/1ps

module updi_prog_top import updi_prog_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	output logic        busy,
	output logic        done,
	output prog_err_e   err_code,
	output logic [23:0] device_id,
	output logic [7:0]  tx_byte,
	output logic        tx_valid,
	input  logic        tx_ready,
	input  logic [7:0]  rx_byte,
	input  logic        rx_valid,
	output logic        rx_ready,
	output logic        break_start,
	input  logic        break_done
);

	updi_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	logic frame_done;
	logic ack_req;
	logic ack_ok;
	logic ack_bad;
	logic rx_timeout;
	logic resp_req;
	logic [RESP_CNT_W-1:0] resp_count;
	updi_resp_t resp;
	logic resp_valid;

	updi_sequencer i_updi_sequencer (
		.clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
		.err_code(err_code), .device_id(device_id),
		.break_start(break_start), .break_done(break_done),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .frame_done(frame_done),
		.resp_req(resp_req), .resp_count(resp_count), .resp(resp), .resp_valid(resp_valid),
		.ack_bad(ack_bad), .rx_timeout(rx_timeout)
	);

	updi_frame_tx i_updi_frame_tx (
		.clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.frame_done(frame_done), .tx_byte(tx_byte), .tx_valid(tx_valid),
		.tx_ready(tx_ready), .ack_req(ack_req), .ack_ok(ack_ok)
	);

	updi_rx_collect i_updi_rx_collect (
		.clk(clk), .rst(rst), .ack_req(ack_req), .ack_ok(ack_ok), .ack_bad(ack_bad),
		.resp_req(resp_req), .resp_count(resp_count), .resp(resp), .resp_valid(resp_valid),
		.rx_byte(rx_byte), .rx_valid(rx_valid), .rx_ready(rx_ready), .rx_timeout(rx_timeout)
	);

endmodule

// File: updi_proto_pkg.sv
// UPDI protocol definitions
package updi_proto_pkg;

	// instruction class, top three bits of the opcode byte
	typedef enum logic [2:0] {
		OP_LDS    = 3'h0,
		OP_LD     = 3'h1,
		OP_STS    = 3'h2,
		OP_ST     = 3'h3,
		OP_LDCS   = 3'h4,
		OP_REPEAT = 3'h5,
		OP_STCS   = 3'h6,
		OP_KEY    = 3'h7
	} updi_opcode_e;

	typedef struct packed {
		updi_opcode_e op;
		logic         rsvd;
		logic [3:0]   addr;
	} updi_cs_op_t;

	typedef struct packed {
		updi_opcode_e op;
		logic         rsvd;
		logic [1:0]   ptr;
		logic [1:0]   size;
	} updi_mem_op_t;

	// LDCS/STCS use the cs view, LD/ST/REPEAT/KEY the mem view
	typedef union packed {
		updi_cs_op_t  cs;
		updi_mem_op_t mem;
	} updi_op_u;

	localparam logic [7:0] UPDI_SYNC = 8'h55;
	localparam logic [7:0] UPDI_ACK  = 8'h40;

	// pointer modes and access sizes
	localparam logic [1:0] PTR_POSTINC = 2'b01;
	localparam logic [1:0] PTR_REG     = 2'b10;
	localparam logic [1:0] SIZE_BYTE   = 2'b00;
	localparam logic [1:0] SIZE_WORD   = 2'b01;
	localparam logic [1:0] KEY_SIZE_64 = 2'b00;

	// ASI control/status register addresses
	localparam logic [3:0] CS_STATUSA    = 4'h0;
	localparam logic [3:0] CS_KEY_STATUS = 4'h7;
	localparam logic [3:0] CS_RESET_REQ  = 4'h8;
	localparam logic [3:0] CS_SYS_STATUS = 4'hB;

	localparam logic [7:0]  RESET_SIGNATURE = 8'h59;
	// "NVMErase", goes out lsb first
	localparam logic [63:0] KEY_CHIPERASE   = 64'h4e56_4d45_7261_7365;
	localparam logic [15:0] SIG_BASE_ADDR   = 16'h1100;
	localparam int          DEVICE_ID_BYTES = 3;

endpackage

// File: updi_rx_collect.sv
// UPDI receive collector
`timescale 1ns/1ps

module updi_rx_collect import updi_proto_pkg::*, updi_prog_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ack_req,
	output logic                  ack_ok,
	output logic                  ack_bad,
	input  logic                  resp_req,
	input  logic [RESP_CNT_W-1:0] resp_count,
	output updi_resp_t            resp,
	output logic                  resp_valid,
	input  logic [7:0]            rx_byte,
	input  logic                  rx_valid,
	output logic                  rx_ready,
	output logic                  rx_timeout
);

	typedef enum logic [1:0] {RX_IDLE, RX_ACK, RX_RESP} rx_mode_e;

	rx_mode_e mode;
	logic [TMO_W-1:0] tmo;
	logic [RESP_CNT_W-1:0] want;
	logic [RESP_CNT_W-1:0] got;
	updi_resp_t resp_q;
	logic take;
	logic tmo_hit;

	assign rx_ready = (mode != RX_IDLE);
	assign take = rx_valid && rx_ready;
	assign tmo_hit = rx_ready && !take && (tmo == TMO_W'(RX_TIMEOUT_CLKS - 1));
	assign resp = resp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= RX_IDLE;
			tmo <= '0;
			ack_ok <= 1'b0;
			ack_bad <= 1'b0;
			resp_valid <= 1'b0;
			rx_timeout <= 1'b0;
		end else begin
			ack_ok <= 1'b0;
			ack_bad <= 1'b0;
			resp_valid <= 1'b0;
			rx_timeout <= 1'b0;
			// gap counter restarts on every byte taken
			if (take || mode == RX_IDLE) begin
				tmo <= '0;
			end else begin
				tmo <= tmo + TMO_W'(1);
			end
			case (mode)
				RX_IDLE: begin
					if (ack_req) begin
						mode <= RX_ACK;
					end else if (resp_req) begin
						mode <= RX_RESP;
						want <= resp_count;
						got <= '0;
					end
				end
				RX_ACK: begin
					// a bad byte or a timeout still releases the transmitter
					if (take) begin
						ack_ok <= 1'b1;
						ack_bad <= (rx_byte != UPDI_ACK);
						mode <= RX_IDLE;
					end else if (tmo_hit) begin
						ack_ok <= 1'b1;
						rx_timeout <= 1'b1;
						mode <= RX_IDLE;
					end
				end
				RX_RESP: begin
					if (take) begin
						resp_q.data[got] <= rx_byte;
						got <= got + RESP_CNT_W'(1);
						if (got + RESP_CNT_W'(1) == want) begin
							resp_q.count <= want;
							resp_valid <= 1'b1;
							mode <= RX_IDLE;
						end
					end else if (tmo_hit) begin
						rx_timeout <= 1'b1;
						mode <= RX_IDLE;
					end
				end
				default: mode <= RX_IDLE;
			endcase
		end
	end

endmodule

// File: updi_sequencer.sv
// UPDI session sequencer
`timescale 1ns/1ps

module updi_sequencer import updi_proto_pkg::*, updi_prog_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	output logic                  busy,
	output logic                  done,
	output prog_err_e             err_code,
	output logic [23:0]           device_id,
	output logic                  break_start,
	input  logic                  break_done,
	output updi_cmd_t             cmd,
	output logic                  cmd_valid,
	input  logic                  cmd_ready,
	input  logic                  frame_done,
	output logic                  resp_req,
	output logic [RESP_CNT_W-1:0] resp_count,
	input  updi_resp_t            resp,
	input  logic                  resp_valid,
	input  logic                  ack_bad,
	input  logic                  rx_timeout
);

	typedef enum logic [2:0] {S_IDLE, S_BREAK, S_ISSUE, S_WAIT, S_DELAY} state_e;

	// session steps in issue order
	typedef enum logic [3:0] {
		STEP_STATUSA,
		STEP_KEY,
		STEP_KEY_STATUS,
		STEP_RST_SET,
		STEP_RST_CLR,
		STEP_SYS_POLL,
		STEP_SIG_PTR,
		STEP_SIG_REPEAT,
		STEP_SIG_LD
	} step_e;

	state_e state;
	step_e step;
	logic [DELAY_W-1:0] dly;
	logic step_end;
	logic [7:0] reply;
	prog_err_e chk_err;

	assign busy = (state != S_IDLE);
	assign cmd_valid = (state == S_ISSUE);
	assign resp_count = cmd.resp_count;
	assign reply = resp.data[0];
	// a step ends on its response, or on the frame when nothing comes back
	assign step_end = (state == S_WAIT) && ((cmd.resp_count == '0) ? frame_done : resp_valid);

	always_comb begin
		cmd = '0;
		case (step)
			STEP_STATUSA: begin
				cmd.op.cs.op = OP_LDCS;
				cmd.op.cs.addr = CS_STATUSA;
				cmd.resp_count = RESP_CNT_W'(1);
			end
			STEP_KEY: begin
				cmd.op.mem.op = OP_KEY;
				cmd.op.mem.size = KEY_SIZE_64;
				cmd.data = KEY_CHIPERASE;
				cmd.data_count = DATA_CNT_W'(MAX_CMD_DATA);
			end
			STEP_KEY_STATUS: begin
				cmd.op.cs.op = OP_LDCS;
				cmd.op.cs.addr = CS_KEY_STATUS;
				cmd.resp_count = RESP_CNT_W'(1);
			end
			STEP_RST_SET, STEP_RST_CLR: begin
				cmd.op.cs.op = OP_STCS;
				cmd.op.cs.addr = CS_RESET_REQ;
				cmd.data[0] = (step == STEP_RST_SET) ? RESET_SIGNATURE : 8'h00;
				cmd.data_count = DATA_CNT_W'(1);
			end
			STEP_SYS_POLL: begin
				cmd.op.cs.op = OP_LDCS;
				cmd.op.cs.addr = CS_SYS_STATUS;
				cmd.resp_count = RESP_CNT_W'(1);
			end
			STEP_SIG_PTR: begin
				// pointer load, target acks after the high address byte
				cmd.op.mem.op = OP_ST;
				cmd.op.mem.ptr = PTR_REG;
				cmd.op.mem.size = SIZE_WORD;
				cmd.data[0] = SIG_BASE_ADDR[7:0];
				cmd.data[1] = SIG_BASE_ADDR[15:8];
				cmd.data_count = DATA_CNT_W'(2);
				cmd.ack_en = 1'b1;
				cmd.ack_idx = ACK_IDX_W'(1);
			end
			STEP_SIG_REPEAT: begin
				cmd.op.mem.op = OP_REPEAT;
				cmd.op.mem.size = SIZE_BYTE;
				cmd.data[0] = 8'(DEVICE_ID_BYTES - 1);
				cmd.data_count = DATA_CNT_W'(1);
			end
			default: begin
				cmd.op.mem.op = OP_LD;
				cmd.op.mem.ptr = PTR_POSTINC;
				cmd.op.mem.size = SIZE_BYTE;
				cmd.resp_count = RESP_CNT_W'(DEVICE_ID_BYTES);
			end
		endcase
	end

	always_comb begin
		chk_err = ERR_NONE;
		if (step == STEP_STATUSA && reply == 8'h00) begin
			chk_err = ERR_STATUS_ZERO;
		end
		// chip-erase key accepted shows up in bit 3
		if (step == STEP_KEY_STATUS && !reply[3]) begin
			chk_err = ERR_KEY_REJECTED;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			step <= STEP_STATUSA;
			dly <= '0;
			done <= 1'b0;
			err_code <= ERR_NONE;
			break_start <= 1'b0;
			resp_req <= 1'b0;
		end else begin
			done <= 1'b0;
			break_start <= 1'b0;
			resp_req <= 1'b0;
			dly <= (state == S_DELAY) ? dly + DELAY_W'(1) : '0;
			if (busy && (ack_bad || rx_timeout)) begin
				state <= S_IDLE;
				done <= 1'b1;
				err_code <= ack_bad ? ERR_BAD_ACK : ERR_TIMEOUT;
			end else begin
				case (state)
					S_IDLE: begin
						if (start) begin
							state <= S_BREAK;
							break_start <= 1'b1;
							err_code <= ERR_NONE;
						end
					end
					S_BREAK: begin
						if (break_done) begin
							step <= STEP_STATUSA;
							state <= S_ISSUE;
						end
					end
					S_ISSUE: begin
						if (cmd_ready) begin
							state <= S_WAIT;
						end
					end
					S_WAIT: begin
						if (frame_done && cmd.resp_count != '0) begin
							resp_req <= 1'b1;
						end
						if (step_end) begin
							if (chk_err != ERR_NONE) begin
								state <= S_IDLE;
								done <= 1'b1;
								err_code <= chk_err;
							end else begin
								case (step)
									STEP_RST_SET: state <= S_DELAY;
									STEP_SYS_POLL: begin
										// bit 0 set means the erase is still running
										if (reply[0]) begin
											state <= S_DELAY;
										end else begin
											step <= STEP_SIG_PTR;
											state <= S_ISSUE;
										end
									end
									STEP_SIG_LD: begin
										device_id <= {resp.data[0], resp.data[1], resp.data[2]};
										state <= S_IDLE;
										done <= 1'b1;
									end
									default: begin
										step <= step_e'(step + 4'd1);
										state <= S_ISSUE;
									end
								endcase
							end
						end
					end
					S_DELAY: begin
						if (dly == DELAY_W'(RESET_DELAY_CLKS - 1)) begin
							step <= (step == STEP_RST_SET) ? STEP_RST_CLR : step;
							state <= S_ISSUE;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

// File: vlog.f
updi_proto_pkg.sv
updi_prog_pkg.sv
updi_frame_tx.sv
updi_rx_collect.sv
updi_sequencer.sv
updi_prog_top.sv
updi_prog_props.sv
tb_updi_prog.sv
